// File: verilog/ReplayQueuePkg.sv
/*
 * Replay queue package
 * Sizes, widths, opcode and MSHR phase encodings, and the queue entry
 * record shared by the replay queue blocks and their testbench.
 */

package ReplayQueuePkg;

    // Queue geometry
    localparam int QueueEntries = 8;
    localparam int QueueIndexWidth = 3;
    localparam int QueueCountWidth = 4;

    // Beats that may still arrive after the upper stages see the stall
    localparam int MemIssueLatency = 2;
    localparam int AlmostFullLevel = QueueEntries - MemIssueLatency;

    // Replay spacing
    localparam int MaxReplayInterval = 3;
    localparam int IntervalWidth = 2;

    localparam int ActiveListIndexWidth = 5;
    localparam int PayloadWidth = 16;
    localparam int MshrCount = 2;
    localparam int MshrIndexWidth = 1;

    typedef logic [QueueIndexWidth-1:0] QueueIndexPath;
    typedef logic [QueueCountWidth-1:0] QueueCountPath;
    typedef logic [IntervalWidth-1:0] IntervalPath;
    typedef logic [ActiveListIndexWidth-1:0] ActiveListIndexPath;
    typedef logic [PayloadWidth-1:0] PayloadPath;
    typedef logic [MshrIndexWidth-1:0] MshrIndexPath;

    typedef enum logic [1:0] {
        MemOpLoad,
        MemOpStore,
        MemOpDiv
    } MemOpType;

    // Phases below MshrPhaseMissWriteCache mean the fill data is not there yet
    typedef enum logic [1:0] {
        MshrPhaseAlloc,
        MshrPhaseMissRequest,
        MshrPhaseMissWriteCache,
        MshrPhaseDone
    } MshrPhase;

    typedef struct packed {
        logic valid;
        PayloadPath payload;
        ActiveListIndexPath alPtr;
    } IntLane;

    typedef struct packed {
        logic valid;
        PayloadPath payload;
        ActiveListIndexPath alPtr;
        MemOpType op;
        logic hasMshr;
        MshrIndexPath mshrId;
    } MemLane;

    typedef struct packed {
        IntLane intLane;
        MemLane memLane;
        IntervalPath interval;
    } ReplayEntry;

endpackage

// File: verilog/ReplayRecorder.sv
/*
 * Replay recorder
 * Packs the issued int and mem lanes into a queue entry, tags it with the
 * number of cycles since the previous recorded beat and decides the push.
 */

`timescale 1ns/1ps

module ReplayRecorder (
    input  logic clock,
    input  logic reset,
    input  logic intRecordValid,
    input  ReplayQueuePkg::PayloadPath intRecordPayload,
    input  ReplayQueuePkg::ActiveListIndexPath intRecordAlPtr,
    input  logic memRecordValid,
    input  ReplayQueuePkg::PayloadPath memRecordPayload,
    input  ReplayQueuePkg::ActiveListIndexPath memRecordAlPtr,
    input  ReplayQueuePkg::MemOpType memRecordOp,
    input  logic memRecordHasMshr,
    input  ReplayQueuePkg::MshrIndexPath memRecordMshrId,
    input  logic full,
    input  logic queueHoldsValid,
    output logic push,
    output ReplayQueuePkg::ReplayEntry recordEntry
);
    import ReplayQueuePkg::*;

    IntervalPath gapCount;
    logic recordValid;

    always_comb begin
        recordEntry.intLane.valid = intRecordValid;
        recordEntry.intLane.payload = intRecordPayload;
        recordEntry.intLane.alPtr = intRecordAlPtr;
        recordEntry.memLane.valid = memRecordValid;
        recordEntry.memLane.payload = memRecordPayload;
        recordEntry.memLane.alPtr = memRecordAlPtr;
        recordEntry.memLane.op = memRecordOp;
        recordEntry.memLane.hasMshr = memRecordHasMshr;
        recordEntry.memLane.mshrId = memRecordMshrId;
        recordEntry.interval = gapCount;
    end

    assign recordValid = intRecordValid || memRecordValid;

    // Empty beats only add to the gap
    assign push = !full && recordValid;

    // Cycles since the last push, saturating
    always_ff @(posedge clock) begin
        if (reset) begin
            gapCount <= '0;
        end else if (push) begin
            gapCount <= '0;
        end else if (gapCount < IntervalPath'(MaxReplayInterval)) begin
            gapCount <= gapCount + 1'b1;
        end
    end

endmodule

// File: verilog/ReplayQueueStorage.sv
/*
 * Replay queue storage
 * Circular entry RAM with head and tail pointers and an occupancy count.
 * Also tracks how many stored beats carry at least one valid lane.
 */

`timescale 1ns/1ps

module ReplayQueueStorage (
    input  logic clock,
    input  logic reset,
    input  logic push,
    input  logic pop,
    input  ReplayQueuePkg::ReplayEntry recordEntry,
    output ReplayQueuePkg::ReplayEntry headEntry,
    output logic empty,
    output logic full,
    output ReplayQueuePkg::QueueCountPath count,
    output logic queueHoldsValid
);
    import ReplayQueuePkg::*;

    ReplayEntry entryRam [QueueEntries];
    QueueIndexPath headPtr;
    QueueIndexPath tailPtr;
    QueueCountPath validCount;
    logic recordHasValid;
    logic headHasValid;

    // Write at tail, read at head without a clock
    always_ff @(posedge clock) begin
        if (push) begin
            entryRam[tailPtr] <= recordEntry;
        end
    end

    assign headEntry = entryRam[headPtr];

    assign empty = (count == '0);
    assign full = (count == QueueCountPath'(QueueEntries));

    always_ff @(posedge clock) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign recordHasValid = recordEntry.intLane.valid || recordEntry.memLane.valid;
    assign headHasValid = headEntry.intLane.valid || headEntry.memLane.valid;

    // Beats with live ops currently in the queue
    always_ff @(posedge clock) begin
        if (reset) begin
            validCount <= '0;
        end else begin
            case ({push && recordHasValid, pop && headHasValid})
                2'b10: validCount <= validCount + 1'b1;
                2'b01: validCount <= validCount - 1'b1;
                default: validCount <= validCount;
            endcase
        end
    end

    assign queueHoldsValid = (validCount != '0);

endmodule

// File: verilog/ReplayIssueGate.sv
/*
 * Replay issue gate
 * Decides when the head beat leaves the queue. Holds it for its stored
 * gap, for a load whose MSHR has no data yet and for a divide on a busy divider.
 */

`timescale 1ns/1ps

module ReplayIssueGate (
    input  logic clock,
    input  logic reset,
    input  logic empty,
    input  ReplayQueuePkg::ReplayEntry headEntry,
    input  ReplayQueuePkg::MshrPhase mshrPhase [ReplayQueuePkg::MshrCount],
    input  logic divBusy,
    output logic pop
);
    import ReplayQueuePkg::*;

    IntervalPath gapCount;
    MshrPhase headPhase;
    logic gapElapsed;
    logic loadWait;
    logic divWait;

    assign headPhase = mshrPhase[headEntry.memLane.mshrId];
    assign gapElapsed = (gapCount >= headEntry.interval);

    // Load that owns an MSHR still waiting for its fill
    assign loadWait = headEntry.memLane.valid
        && (headEntry.memLane.op == MemOpLoad)
        && headEntry.memLane.hasMshr
        && (headPhase < MshrPhaseMissWriteCache);

    // Divider interlock
    assign divWait = headEntry.memLane.valid
        && (headEntry.memLane.op == MemOpDiv)
        && divBusy;

    always_comb begin
        if (empty || !gapElapsed) begin
            pop = 1'b0;
        end else begin
            pop = !(loadWait || divWait);
        end
    end

    // Cycles since the last pop, saturating
    always_ff @(posedge clock) begin
        if (reset) begin
            gapCount <= '0;
        end else if (pop) begin
            gapCount <= '0;
        end else if (gapCount < IntervalPath'(MaxReplayInterval)) begin
            gapCount <= gapCount + 1'b1;
        end
    end

endmodule

// File: verilog/ReplayOutputStage.sv
/*
 * Replay output stage
 * Registers the popped beat, masks ops caught by a recent recovery and
 * drives the upper-stage stall and the flushed-op indication.
 */

`timescale 1ns/1ps

module ReplayOutputStage (
    input  logic clock,
    input  logic reset,
    input  logic pop,
    input  ReplayQueuePkg::ReplayEntry headEntry,
    input  ReplayQueuePkg::QueueCountPath count,
    input  logic recovery,
    input  ReplayQueuePkg::ActiveListIndexPath flushRangeHead,
    input  ReplayQueuePkg::ActiveListIndexPath flushRangeTail,
    output logic replay,
    output logic intReplayValid,
    output ReplayQueuePkg::PayloadPath intReplayPayload,
    output ReplayQueuePkg::ActiveListIndexPath intReplayAlPtr,
    output logic memReplayValid,
    output ReplayQueuePkg::PayloadPath memReplayPayload,
    output ReplayQueuePkg::ActiveListIndexPath memReplayAlPtr,
    output ReplayQueuePkg::MemOpType memReplayOp,
    output logic stallUpper,
    output logic flushedOpExist
);
    import ReplayQueuePkg::*;

    logic intValidReg;
    logic memValidReg;
    QueueCountPath flushCount;
    ActiveListIndexPath flushHeadReg;
    ActiveListIndexPath flushTailReg;
    logic flushInt;
    logic flushMem;

    // Range is head inclusive to tail exclusive on the circular active list
    function automatic logic inFlushRange(input ActiveListIndexPath ptr,
                                          input ActiveListIndexPath head,
                                          input ActiveListIndexPath tail);
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            replay <= 1'b0;
            intValidReg <= 1'b0;
            memValidReg <= 1'b0;
        end else begin
            replay <= pop && (headEntry.intLane.valid || headEntry.memLane.valid);
            intValidReg <= pop && headEntry.intLane.valid;
            memValidReg <= pop && headEntry.memLane.valid;
        end
    end

    always_ff @(posedge clock) begin
        intReplayPayload <= headEntry.intLane.payload;
        intReplayAlPtr <= headEntry.intLane.alPtr;
        memReplayPayload <= headEntry.memLane.payload;
        memReplayAlPtr <= headEntry.memLane.alPtr;
        memReplayOp <= headEntry.memLane.op;
    end

    // Every beat queued at recovery time may hold a flushed op
    always_ff @(posedge clock) begin
        if (reset) begin
            flushCount <= '0;
        end else if (recovery) begin
            flushCount <= count;
            flushHeadReg <= flushRangeHead;
            flushTailReg <= flushRangeTail;
        end else if (flushedOpExist && replay) begin
            flushCount <= flushCount - 1'b1;
        end
    end

    assign flushedOpExist = (flushCount != '0);

    assign flushInt = flushedOpExist
        && inFlushRange(intReplayAlPtr, flushHeadReg, flushTailReg);
    assign flushMem = flushedOpExist
        && inFlushRange(memReplayAlPtr, flushHeadReg, flushTailReg);

    assign intReplayValid = intValidReg && !flushInt;
    assign memReplayValid = memValidReg && !flushMem;

    assign stallUpper = replay || (count >= QueueCountPath'(AlmostFullLevel));

endmodule

// File: verilog/ReplayQueue.sv
/*
 * Replay queue
 * Records issued beats with their spacing and replays them in order,
 * holding on MSHR fills and the divider, with selective flush masking.
 */

`timescale 1ns/1ps

module ReplayQueue (
    input  logic clock,
    input  logic reset,
    input  logic intRecordValid,
    input  ReplayQueuePkg::PayloadPath intRecordPayload,
    input  ReplayQueuePkg::ActiveListIndexPath intRecordAlPtr,
    input  logic memRecordValid,
    input  ReplayQueuePkg::PayloadPath memRecordPayload,
    input  ReplayQueuePkg::ActiveListIndexPath memRecordAlPtr,
    input  ReplayQueuePkg::MemOpType memRecordOp,
    input  logic memRecordHasMshr,
    input  ReplayQueuePkg::MshrIndexPath memRecordMshrId,
    input  ReplayQueuePkg::MshrPhase mshrPhase [ReplayQueuePkg::MshrCount],
    input  logic divBusy,
    input  logic recovery,
    input  ReplayQueuePkg::ActiveListIndexPath flushRangeHead,
    input  ReplayQueuePkg::ActiveListIndexPath flushRangeTail,
    output logic replay,
    output logic intReplayValid,
    output ReplayQueuePkg::PayloadPath intReplayPayload,
    output ReplayQueuePkg::ActiveListIndexPath intReplayAlPtr,
    output logic memReplayValid,
    output ReplayQueuePkg::PayloadPath memReplayPayload,
    output ReplayQueuePkg::ActiveListIndexPath memReplayAlPtr,
    output ReplayQueuePkg::MemOpType memReplayOp,
    output logic stallUpper,
    output logic flushedOpExist
);
    import ReplayQueuePkg::*;

    logic push;
    logic pop;
    logic empty;
    logic full;
    logic queueHoldsValid;
    QueueCountPath count;
    ReplayEntry recordEntry;
    ReplayEntry headEntry;

    ReplayRecorder recorder (
        .clock(clock), .reset(reset),
        .intRecordValid(intRecordValid), .intRecordPayload(intRecordPayload),
        .intRecordAlPtr(intRecordAlPtr),
        .memRecordValid(memRecordValid), .memRecordPayload(memRecordPayload),
        .memRecordAlPtr(memRecordAlPtr), .memRecordOp(memRecordOp),
        .memRecordHasMshr(memRecordHasMshr), .memRecordMshrId(memRecordMshrId),
        .full(full), .queueHoldsValid(queueHoldsValid),
        .push(push), .recordEntry(recordEntry)
    );

    ReplayQueueStorage storage (
        .clock(clock), .reset(reset), .push(push), .pop(pop),
        .recordEntry(recordEntry), .headEntry(headEntry),
        .empty(empty), .full(full), .count(count), .queueHoldsValid(queueHoldsValid)
    );

    ReplayIssueGate issueGate (
        .clock(clock), .reset(reset), .empty(empty), .headEntry(headEntry),
        .mshrPhase(mshrPhase), .divBusy(divBusy), .pop(pop)
    );

    ReplayOutputStage outputStage (
        .clock(clock), .reset(reset), .pop(pop), .headEntry(headEntry), .count(count),
        .recovery(recovery), .flushRangeHead(flushRangeHead),
        .flushRangeTail(flushRangeTail), .replay(replay),
        .intReplayValid(intReplayValid), .intReplayPayload(intReplayPayload),
        .intReplayAlPtr(intReplayAlPtr),
        .memReplayValid(memReplayValid), .memReplayPayload(memReplayPayload),
        .memReplayAlPtr(memReplayAlPtr), .memReplayOp(memReplayOp),
        .stallUpper(stallUpper), .flushedOpExist(flushedOpExist)
    );

endmodule

// File: verif/ReplayQueue_props.sv
/*
 * Replay queue properties
 * Concurrent checks bound onto the replay queue top level.
 */

`timescale 1ns/1ps

module ReplayQueueProps (
    input logic clock,
    input logic reset,
    input logic replay,
    input logic stallUpper,
    input logic flushedOpExist,
    input logic intReplayValid,
    input logic memReplayValid
);

    // The upper stages must hold while a beat replays
    assert property (@(posedge clock) disable iff (reset) replay |-> stallUpper)
        else $error("replay without stallUpper");

    assert property (@(posedge clock) reset |=> !flushedOpExist)
        else $error("flushedOpExist set after reset");

    // Lane valids only ever appear with the replay strobe
    assert property (@(posedge clock) disable iff (reset)
        (intReplayValid || memReplayValid) |-> replay)
        else $error("replay lane valid without replay");

endmodule

bind ReplayQueue ReplayQueueProps props (
    .clock(clock), .reset(reset), .replay(replay), .stallUpper(stallUpper),
    .flushedOpExist(flushedOpExist), .intReplayValid(intReplayValid),
    .memReplayValid(memReplayValid)
);

// File: verif/ReplayQueueTb.sv
/*
 * Replay queue testbench
 * Plays cycle vectors from a file into the replay queue and checks order,
 * spacing, MSHR and divider holds, stall level and flush masking.
 */

`timescale 1ns/1ps

module ReplayQueueTb;
    import ReplayQueuePkg::*;

    localparam int MaxVectors = 64;
    localparam int FieldCount = 17;
    localparam int ResetCycles = 5;

    logic clock;
    logic reset;
    logic intRecordValid;
    PayloadPath intRecordPayload;
    ActiveListIndexPath intRecordAlPtr;
    logic memRecordValid;
    PayloadPath memRecordPayload;
    ActiveListIndexPath memRecordAlPtr;
    MemOpType memRecordOp;
    logic memRecordHasMshr;
    MshrIndexPath memRecordMshrId;
    MshrPhase mshrPhase [MshrCount];
    logic divBusy;
    logic recovery;
    ActiveListIndexPath flushRangeHead;
    ActiveListIndexPath flushRangeTail;
    logic replay;
    logic intReplayValid;
    PayloadPath intReplayPayload;
    ActiveListIndexPath intReplayAlPtr;
    logic memReplayValid;
    PayloadPath memReplayPayload;
    ActiveListIndexPath memReplayAlPtr;
    MemOpType memReplayOp;
    logic stallUpper;
    logic flushedOpExist;

    // Vector table and reference model state
    string vecTag [MaxVectors];
    int vecField [MaxVectors][FieldCount];
    string phaseTag;
    int vectorCount;
    int cycleCount;
    int cycleLimit;
    int errorCount;
    int seed;
    ReplayEntry modelQueue [$];
    PayloadPath expectedMem [$];
    int queued;
    int flushLeft;
    int tbGap;
    int sinceReplay;
    int replayCount;
    int pushCount;
    ActiveListIndexPath flushRangeHeadLatched;
    ActiveListIndexPath flushRangeTailLatched;

    ReplayQueue UUT (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: queue did not drain within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic expectTrue(input bit ok, input string msg);
        assert (ok) else begin
            errorCount++;
            $display("ERR %0t: %s (%s phase)", $time, msg, phaseTag);
        end
    endtask

    // Offset from head compared with the range length, both modulo the list size
    function automatic bit inFlushWindow(input ActiveListIndexPath ptr);
        ActiveListIndexPath offset;
        ActiveListIndexPath span;
        offset = ptr - flushRangeHeadLatched;
        span = flushRangeTailLatched - flushRangeHeadLatched;
        return offset < span;
    endfunction

    task automatic driveIdle();
        phaseTag = "drain";
        intRecordValid = 1'b0;
        intRecordPayload = PayloadPath'($random(seed));
        intRecordAlPtr = '0;
        memRecordValid = 1'b0;
        memRecordPayload = PayloadPath'($random(seed));
        memRecordAlPtr = '0;
        memRecordOp = MemOpLoad;
        memRecordHasMshr = 1'b0;
        memRecordMshrId = '0;
        mshrPhase[0] = MshrPhaseDone;
        mshrPhase[1] = MshrPhaseDone;
        divBusy = 1'b0;
        recovery = 1'b0;
        flushRangeHead = '0;
        flushRangeTail = '0;
    endtask

    task automatic driveVector(input int n);
        phaseTag = vecTag[n];
        intRecordValid = vecField[n][0][0];
        intRecordPayload = intRecordValid ? PayloadPath'(vecField[n][1])
                                          : PayloadPath'($random(seed));
        intRecordAlPtr = ActiveListIndexPath'(vecField[n][2]);
        memRecordValid = vecField[n][3][0];
        memRecordPayload = memRecordValid ? PayloadPath'(vecField[n][4])
                                          : PayloadPath'($random(seed));
        memRecordAlPtr = ActiveListIndexPath'(vecField[n][5]);
        memRecordOp = MemOpType'(vecField[n][6]);
        memRecordHasMshr = vecField[n][7][0];
        memRecordMshrId = MshrIndexPath'(vecField[n][8]);
        mshrPhase[0] = MshrPhase'(vecField[n][9]);
        mshrPhase[1] = MshrPhase'(vecField[n][10]);
        divBusy = vecField[n][11][0];
        recovery = vecField[n][12][0];
        flushRangeHead = ActiveListIndexPath'(vecField[n][13]);
        flushRangeTail = ActiveListIndexPath'(vecField[n][14]);
        if (vecField[n][15] != 0) begin
            expectedMem.push_back(PayloadPath'(vecField[n][16]));
        end
    endtask

    // Inputs still hold the values sampled at the last rising edge
    task automatic checkCycle();
        ReplayEntry exp;
        ReplayEntry rec;
        bit maskInt;
        bit maskMem;
        if (recovery) begin
            flushLeft = queued;
            flushRangeHeadLatched = flushRangeHead;
            flushRangeTailLatched = flushRangeTail;
        end
        expectTrue(flushedOpExist == (flushLeft != 0), "flushedOpExist mismatch");
        sinceReplay++;
        if (replay) begin
            replayCount++;
            if (modelQueue.size() == 0) begin
                expectTrue(1'b0, "replay with no beat queued");
            end else begin
                exp = modelQueue.pop_front();
                queued--;
                maskInt = (flushLeft != 0) && inFlushWindow(exp.intLane.alPtr);
                maskMem = (flushLeft != 0) && inFlushWindow(exp.memLane.alPtr);
                expectTrue(intReplayValid == (exp.intLane.valid && !maskInt),
                           "int lane valid mismatch");
                expectTrue(memReplayValid == (exp.memLane.valid && !maskMem),
                           "mem lane valid mismatch");
                if (exp.intLane.valid) begin
                    expectTrue(intReplayPayload == exp.intLane.payload, "int payload mismatch");
                    expectTrue(intReplayAlPtr == exp.intLane.alPtr, "int pointer mismatch");
                end
                if (exp.memLane.valid) begin
                    expectTrue(memReplayPayload == exp.memLane.payload, "mem payload mismatch");
                    expectTrue(memReplayAlPtr == exp.memLane.alPtr, "mem pointer mismatch");
                    expectTrue(memReplayOp == exp.memLane.op, "mem op mismatch");
                    if (expectedMem.size() > 0) begin
                        expectTrue(memReplayPayload == expectedMem.pop_front(),
                                   "mem payload differs from vector file");
                    end
                    if (exp.memLane.op == MemOpLoad && exp.memLane.hasMshr) begin
                        expectTrue(mshrPhase[exp.memLane.mshrId] >= MshrPhaseMissWriteCache,
                                   "load replayed before MSHR fill");
                    end
                    if (exp.memLane.op == MemOpDiv) begin
                        expectTrue(!divBusy, "divide replayed while divider busy");
                    end
                end
                // Stored gap counts the empty cycles between two beats
                if (replayCount > 1) begin
                    expectTrue(sinceReplay > exp.interval, "replay spacing too short");
                end
                sinceReplay = 0;
                if (flushLeft != 0) begin
                    flushLeft--;
                end
            end
        end
        if (intRecordValid || memRecordValid) begin
            rec.intLane.valid = intRecordValid;
            rec.intLane.payload = intRecordPayload;
            rec.intLane.alPtr = intRecordAlPtr;
            rec.memLane.valid = memRecordValid;
            rec.memLane.payload = memRecordPayload;
            rec.memLane.alPtr = memRecordAlPtr;
            rec.memLane.op = memRecordOp;
            rec.memLane.hasMshr = memRecordHasMshr;
            rec.memLane.mshrId = memRecordMshrId;
            rec.interval = IntervalPath'(tbGap);
            modelQueue.push_back(rec);
            queued++;
            pushCount++;
            tbGap = 0;
            expectTrue(queued <= QueueEntries, "vectors overfill the queue");
        end else if (tbGap < MaxReplayInterval) begin
            tbGap++;
        end
        expectTrue(stallUpper == (replay || queued >= AlmostFullLevel), "stallUpper mismatch");
    endtask

    initial begin
        int fd;
        string line;
        string tag;
        int count;
        seed = 70453;
        errorCount = 0;
        cycleCount = 0;
        cycleLimit = 0;
        queued = 0;
        flushLeft = 0;
        tbGap = 0;
        sinceReplay = 0;
        replayCount = 0;
        pushCount = 0;
        vectorCount = 0;
        reset = 1'b1;
        driveIdle();
        fd = $fopen("verif/replay_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            $display("Test failed");
            $finish;
        end else begin
            while (!$feof(fd) && vectorCount < MaxVectors) begin
                count = $fgets(line, fd);
                if (count > 1 && line[0] != "#") begin
                    count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        tag, vecField[vectorCount][0], vecField[vectorCount][1],
                        vecField[vectorCount][2], vecField[vectorCount][3],
                        vecField[vectorCount][4], vecField[vectorCount][5],
                        vecField[vectorCount][6], vecField[vectorCount][7],
                        vecField[vectorCount][8], vecField[vectorCount][9],
                        vecField[vectorCount][10], vecField[vectorCount][11],
                        vecField[vectorCount][12], vecField[vectorCount][13],
                        vecField[vectorCount][14], vecField[vectorCount][15],
                        vecField[vectorCount][16]);
                    if (count == FieldCount + 1) begin
                        vecTag[vectorCount] = tag;
                        vectorCount++;
                    end
                end
            end
            $fclose(fd);
            cycleLimit = vectorCount + 64 + ResetCycles;
            repeat (ResetCycles) @(posedge clock);
            @(negedge clock);
            reset = 1'b0;
            driveVector(0);
            for (int n = 1; n < vectorCount; n++) begin
                @(negedge clock);
                checkCycle();
                driveVector(n);
            end
            @(negedge clock);
            checkCycle();
            driveIdle();
            while (modelQueue.size() != 0 || flushLeft != 0) begin
                @(negedge clock);
                checkCycle();
                driveIdle();
            end
            // An empty queue must stay silent for a full replay interval
            repeat (MaxReplayInterval + 1) begin
                @(negedge clock);
                checkCycle();
                driveIdle();
            end
            expectTrue(replayCount == pushCount, "replay count differs from recorded beats");
            expectTrue(expectedMem.size() == 0, "expected mem payloads left over");
            $display("Errors: %0d, replays: %0d, recorded: %0d",
                     errorCount, replayCount, pushCount);
            if (errorCount == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

// File: verif/replay_vectors.txt
# tag intValid intPayload intAlPtr memValid memPayload memAlPtr memOp hasMshr mshrId
# phase0 phase1 divBusy recovery flushHead flushTail expFlag expMemPayload (all hex)
order 1 0011 01 1 00a1 02 0 0 0 3 3 0 0 00 00 1 00a1
order 0 0000 00 0 0000 00 0 0 0 3 3 0 0 00 00 0 0000
order 0 0000 00 0 0000 00 0 0 0 3 3 0 0 00 00 0 0000
order 1 0012 03 1 00a2 04 1 0 0 3 3 0 0 00 00 1 00a2
order 0 0000 00 1 00a3 05 0 0 0 3 3 0 0 00 00 1 00a3
order 1 0014 06 0 0000 00 0 0 0 3 3 0 0 00 00 0 0000
mshr 0 0000 00 1 00b1 07 0 1 1 3 1 0 0 00 00 1 00b1
mshr 1 0015 08 0 0000 00 0 0 0 3 1 0 0 00 00 0 0000
mshr 0 0000 00 0 0000 00 0 0 0 3 1 0 0 00 00 0 0000
mshr 0 0000 00 0 0000 00 0 0 0 3 1 0 0 00 00 0 0000
mshr 0 0000 00 0 0000 00 0 0 0 3 1 0 0 00 00 0 0000
mshr 0 0000 00 0 0000 00 0 0 0 3 2 0 0 00 00 0 0000
idle 0 0000 00 0 0000 00 0 0 0 3 3 0 0 00 00 0 0000
idle 0 0000 00 0 0000 00 0 0 0 3 3 0 0 00 00 0 0000
idle 0 0000 00 0 0000 00 0 0 0 3 3 0 0 00 00 0 0000
div 0 0000 00 1 00c1 09 2 0 0 3 3 1 0 00 00 1 00c1
div 1 0016 0a 1 00c2 0a 1 0 0 3 3 1 0 00 00 1 00c2
div 0 0000 00 1 00c3 0b 0 0 0 3 3 1 0 00 00 1 00c3
div 1 0017 0c 0 0000 00 0 0 0 3 3 1 0 00 00 0 0000
div 0 0000 00 1 00c4 0d 1 0 0 3 3 1 0 00 00 1 00c4
div 1 0018 0e 1 00c5 0f 0 0 0 3 3 1 0 00 00 1 00c5
div 0 0000 00 0 0000 00 0 0 0 3 3 1 0 00 00 0 0000
flush 0 0000 00 0 0000 00 0 0 0 3 3 1 1 0a 0e 0 0000
div 0 0000 00 0 0000 00 0 0 0 3 3 1 0 00 00 0 0000
div 0 0000 00 0 0000 00 0 0 0 3 3 0 0 00 00 0 0000

// File: project.f
verilog/ReplayQueuePkg.sv
verilog/ReplayRecorder.sv
verilog/ReplayQueueStorage.sv
verilog/ReplayIssueGate.sv
verilog/ReplayOutputStage.sv
verilog/ReplayQueue.sv
verif/ReplayQueue_props.sv
verif/ReplayQueueTb.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = ReplayQueueTb
FILELIST = project.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: compile
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
